/* eth_tx.f */
+incdir+hw
hw/eth_tx_pkg.sv
hw/crc32_d8.sv
hw/arp_tx.sv
hw/ip_tx.sv
hw/mac_tx_mode.sv
hw/mac_tx.sv
hw/eth_tx_top.sv
dv/tb_eth_tx.sv

/* run_sim.sh */
#!/bin/sh
# builds the eth_tx testbench with verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_eth_tx \
  -f eth_tx.f -o tb_eth_tx > build.log 2>&1 \
  && ./obj_dir/tb_eth_tx > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "test failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "test passed" sim.log || { echo "no result in sim.log"; exit 1; }
echo "PASS"

/* dv/tb_eth_tx.sv */
/*
 * directed testbench for the ethernet transmit top level.
 * drives arp and ip sends, captures every gmii frame and compares it
 * with a frame model built here, fcs and ip header checksum included.
 */
`timescale 1ns/10ps
`default_nettype none
`include "eth_tx_cfg.svh"

module tb_eth_tx;
  import eth_tx_pkg::*;

  localparam int        START_TIMEOUT = 400; // cycles until tx_en must rise.
  localparam int        MAX_FRAME     = 256;
  localparam int        IDLE_TIMEOUT  = 200;
  localparam mac_addr_t LOCAL_MAC     = `ETH_LOCAL_MAC;
  localparam ip_addr_t  LOCAL_IP      = `ETH_LOCAL_IP;

  logic      clk;
  logic      rst_n;
  logic      arp_send;
  ip_addr_t  arp_target_ip;
  logic      ip_wr;
  byte_t     ip_wr_data;
  logic      ip_send;
  mac_addr_t ip_dst_mac;
  ip_addr_t  ip_dst_ip;
  byte_t     ip_protocol;
  logic      arp_busy;
  logic      ip_busy;
  logic      gmii_tx_en;
  byte_t     gmii_txd;

  int          errors;
  int          checks;
  logic [31:0] rng;
  logic [15:0] next_id; // expected ip identification.
  byte_t       exp_q[$];
  byte_t       rx_q[$];
  byte_t       pay_q[$];

  eth_tx_top u_eth_tx_top (
    .clk(clk), .rst_n(rst_n), .arp_send(arp_send), .arp_target_ip(arp_target_ip),
    .ip_wr(ip_wr), .ip_wr_data(ip_wr_data), .ip_send(ip_send), .ip_dst_mac(ip_dst_mac),
    .ip_dst_ip(ip_dst_ip), .ip_protocol(ip_protocol), .arp_busy(arp_busy),
    .ip_busy(ip_busy), .gmii_tx_en(gmii_tx_en), .gmii_txd(gmii_txd)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng = x;
    return x;
  endfunction

  // ones' complement end-around carry.
  function automatic logic [15:0] fold_carries(input logic [31:0] s);
    logic [31:0] r;
    r = s;
    while (r[31:16] != 16'h0)
      r = {16'h0, r[15:0]} + {16'h0, r[31:16]};
    return r[15:0];
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("checks %0d, errors %0d", checks, errors);
    $display("test failed");
    $finish;
  endtask

  task automatic tick();
    @(posedge clk);
    #1; // inputs change just after the edge.
  endtask

  task automatic push_bytes(input logic [63:0] v, input int n);
    int i;
    for (i = n - 1; i >= 0; i--)
      exp_q.push_back(v[i*8 +: 8]); // big endian on the wire.
  endtask

  task automatic fill_payload(input int n);
    pay_q = {};
    repeat (n)
      pay_q.push_back(8'(next_rand()));
  endtask

  task automatic build_arp_body(input ip_addr_t tgt);
    exp_q = {};
    push_bytes(64'hFFFF_FFFF_FFFF, 6); // broadcast.
    push_bytes(64'(LOCAL_MAC), 6);
    push_bytes(64'h0806, 2);
    push_bytes(64'h0001, 2); // ethernet hardware.
    push_bytes(64'h0800, 2);
    push_bytes(64'h0604, 2); // address lengths.
    push_bytes(64'h0001, 2); // request.
    push_bytes(64'(LOCAL_MAC), 6);
    push_bytes(64'(LOCAL_IP), 4);
    push_bytes(64'h0, 6);
    push_bytes(64'(tgt), 4);
  endtask

  task automatic build_ip_body(input mac_addr_t mac, input ip_addr_t ip,
                               input byte_t proto, input logic [15:0] id);
    logic [15:0] hw [10];
    logic [31:0] sum;
    int          i;
    hw[0] = 16'h4500;
    hw[1] = 16'(20 + pay_q.size());
    hw[2] = id;
    hw[3] = 16'h4000; // don't fragment.
    hw[4] = {8'd64, proto};
    hw[5] = 16'h0;
    hw[6] = LOCAL_IP[31:16];
    hw[7] = LOCAL_IP[15:0];
    hw[8] = ip[31:16];
    hw[9] = ip[15:0];
    sum = 32'h0;
    for (i = 0; i < 10; i++)
      sum = sum + {16'h0, hw[i]};
    hw[5] = ~fold_carries(sum);
    exp_q = {};
    push_bytes(64'(mac), 6);
    push_bytes(64'(LOCAL_MAC), 6);
    push_bytes(64'h0800, 2);
    for (i = 0; i < 10; i++)
      push_bytes(64'(hw[i]), 2);
    foreach (pay_q[j])
      exp_q.push_back(pay_q[j]);
  endtask

  // turns the body in exp_q into the full wire frame.
  task automatic add_framing();
    byte_t       body[$];
    logic [31:0] c;
    int          k;
    body = exp_q;
    while (body.size() < `ETH_MIN_FRAME)
      body.push_back(8'h00);
    c = 32'hFFFF_FFFF;
    foreach (body[i])
    begin
      c = c ^ {24'h0, body[i]};
      for (k = 0; k < 8; k++)
        c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
    end
    c = ~c;
    exp_q = {};
    repeat (7)
      exp_q.push_back(8'h55);
    exp_q.push_back(8'hD5);
    foreach (body[i])
      exp_q.push_back(body[i]);
    for (k = 0; k < 4; k++)
      exp_q.push_back(c[k*8 +: 8]); // fcs low byte first.
  endtask

  task automatic collect_frame(output int idle);
    int waited;
    waited = 0;
    rx_q = {};
    @(negedge clk);
    while (!gmii_tx_en && waited < START_TIMEOUT)
    begin
      waited++;
      @(negedge clk);
    end
    if (!gmii_tx_en)
      abort_run("no frame appeared on gmii within the timeout");
    while (gmii_tx_en && rx_q.size() < MAX_FRAME)
    begin
      rx_q.push_back(gmii_txd);
      @(negedge clk);
    end
    if (gmii_tx_en)
      abort_run("gmii_tx_en stayed high past the longest legal frame");
    idle = waited;
  endtask

  task automatic check_frame(input string what);
    int shown;
    checks++;
    shown = 0;
    if (rx_q.size() != exp_q.size())
    begin
      errors++;
      $display("Error at time %0t: %s frame has %0d bytes, expected %0d",
               $time, what, rx_q.size(), exp_q.size());
    end
    else
    begin
      foreach (rx_q[i])
      begin
        if (rx_q[i] !== exp_q[i])
        begin
          errors++;
          if (shown < 4)
            $display("Error at time %0t: %s byte %0d is %h, expected %h",
                     $time, what, i, rx_q[i], exp_q[i]);
          shown++;
        end
      end
    end
  endtask

  // ip header starts after preamble, sfd and the 14-byte mac header.
  task automatic check_header_sum();
    logic [31:0] sum;
    int          i;
    checks++;
    if (rx_q.size() < 42)
    begin
      errors++;
      $display("Error at time %0t: frame too short to hold an ip header", $time);
      return;
    end
    sum = 32'h0;
    for (i = 0; i < 10; i++)
      sum = sum + {16'h0, rx_q[22 + 2*i], rx_q[23 + 2*i]};
    if (fold_carries(sum) !== 16'hFFFF)
    begin
      errors++;
      $display("Error at time %0t: ip header sums to %h, expected ffff",
               $time, fold_carries(sum));
    end
  endtask

  task automatic check_idle(input string when);
    checks++;
    if (gmii_tx_en !== 1'b0 || arp_busy !== 1'b0 || ip_busy !== 1'b0)
    begin
      errors++;
      $display("Error at time %0t: outputs not idle %s (tx_en %b arp_busy %b ip_busy %b)",
               $time, when, gmii_tx_en, arp_busy, ip_busy);
    end
  endtask

  task automatic send_arp(input ip_addr_t tgt);
    tick();
    arp_target_ip = tgt;
    arp_send      = 1'b1;
    tick();
    arp_send = 1'b0;
  endtask

  task automatic write_payload();
    foreach (pay_q[i])
    begin
      tick();
      ip_wr      = 1'b1;
      ip_wr_data = pay_q[i];
    end
    tick();
    ip_wr = 1'b0;
  endtask

  task automatic send_ip(input mac_addr_t mac, input ip_addr_t ip, input byte_t proto);
    tick();
    ip_dst_mac  = mac;
    ip_dst_ip   = ip;
    ip_protocol = proto;
    ip_send     = 1'b1;
    tick();
    ip_send = 1'b0;
  endtask

  task automatic wait_ip_idle();
    int n;
    n = 0;
    while (ip_busy && n < IDLE_TIMEOUT)
    begin
      tick();
      n++;
    end
    if (ip_busy)
      abort_run("ip source stayed busy past the timeout");
  endtask

  task automatic wait_arp_idle();
    int n;
    n = 0;
    while (arp_busy && n < IDLE_TIMEOUT)
    begin
      tick();
      n++;
    end
    if (arp_busy)
      abort_run("arp source stayed busy past the timeout");
  endtask

  task automatic test_reset();
    @(posedge clk);
    @(negedge clk);
    check_idle("during reset");
    @(posedge clk);
    #1 rst_n = 1'b1; // two cycles of reset.
    repeat (20)
    begin
      @(negedge clk);
      check_idle("after reset");
    end
  endtask

  task automatic test_arp();
    ip_addr_t tgt;
    int       idle;
    tgt = next_rand();
    send_arp(tgt);
    collect_frame(idle);
    build_arp_body(tgt);
    add_framing();
    check_frame("arp");
  endtask

  task automatic run_ip_packet(input int len);
    mac_addr_t mac;
    ip_addr_t  ip;
    int        idle;
    mac = {16'(next_rand()), next_rand()};
    ip  = next_rand();
    fill_payload(len);
    write_payload();
    send_ip(mac, ip, 8'h11);
    collect_frame(idle);
    build_ip_body(mac, ip, 8'h11, next_id);
    next_id++;
    add_framing();
    check_frame($sformatf("ip len %0d", len));
    check_header_sum();
  endtask

  task automatic test_ip_lengths();
    run_ip_packet(1);
    run_ip_packet(10);
    run_ip_packet(64);
  endtask

  task automatic test_arp_ip_tie();
    ip_addr_t  tgt_lead;
    ip_addr_t  tgt;
    mac_addr_t mac;
    ip_addr_t  ip;
    byte_t     lead_q[$];
    byte_t     arp_q[$];
    byte_t     ip_q[$];
    int        idle;
    tgt_lead = next_rand();
    tgt      = next_rand();
    mac      = {16'(next_rand()), next_rand()};
    ip       = next_rand();
    fill_payload(20);
    write_payload();
    fork
      begin
        collect_frame(idle);
        lead_q = rx_q;
        collect_frame(idle);
        arp_q = rx_q;
        collect_frame(idle);
      end
      begin
        send_arp(tgt_lead);
        wait_arp_idle(); // leading frame still holds the framer.
        tick();
        arp_target_ip = tgt;
        arp_send      = 1'b1;
        ip_dst_mac    = mac;
        ip_dst_ip     = ip;
        ip_protocol   = 8'h06;
        ip_send       = 1'b1; // same cycle as arp.
        tick();
        arp_send = 1'b0;
        ip_send  = 1'b0;
      end
    join
    ip_q = rx_q;
    rx_q = lead_q;
    build_arp_body(tgt_lead);
    add_framing();
    check_frame("arp ahead of tie");
    rx_q = arp_q;
    build_arp_body(tgt);
    add_framing();
    check_frame("arp in tie");
    rx_q = ip_q;
    build_ip_body(mac, ip, 8'h06, next_id);
    next_id++;
    add_framing();
    check_frame("ip after tie");
    check_header_sum();
  endtask

  task automatic test_back_to_back();
    byte_t     pay1_q[$];
    byte_t     pay2_q[$];
    byte_t     first_q[$];
    byte_t     second_q[$];
    mac_addr_t mac;
    ip_addr_t  ip;
    int        idle_a;
    int        idle_b;
    mac = {16'(next_rand()), next_rand()};
    ip  = next_rand();
    fill_payload(30);
    pay2_q = pay_q;
    fill_payload(10);
    pay1_q = pay_q;
    write_payload();
    send_ip(mac, ip, 8'h11);
    fork
      begin
        collect_frame(idle_a);
        first_q = rx_q;
        collect_frame(idle_b);
      end
      begin
        wait_ip_idle(); // second packet queues behind the framer.
        pay_q = pay2_q;
        write_payload();
        send_ip(mac, ip, 8'h11);
      end
    join
    second_q = rx_q;
    rx_q  = first_q;
    pay_q = pay1_q;
    build_ip_body(mac, ip, 8'h11, next_id);
    next_id++;
    add_framing();
    check_frame("first back-to-back ip");
    rx_q  = second_q;
    pay_q = pay2_q;
    build_ip_body(mac, ip, 8'h11, next_id);
    next_id++;
    add_framing();
    check_frame("second back-to-back ip");
    check_header_sum();
    checks++;
    // one more low sample ended the first frame.
    if (idle_b + 1 < `ETH_IFG)
    begin
      errors++;
      $display("Error at time %0t: gap of %0d idle cycles, expected at least %0d",
               $time, idle_b + 1, `ETH_IFG);
    end
  endtask

  initial
  begin
    rst_n         = 1'b0;
    arp_send      = 1'b0;
    arp_target_ip = '0;
    ip_wr         = 1'b0;
    ip_wr_data    = '0;
    ip_send       = 1'b0;
    ip_dst_mac    = '0;
    ip_dst_ip     = '0;
    ip_protocol   = '0;
    errors        = 0;
    checks        = 0;
    rng           = 32'd76;
    next_id       = 16'h0;

    test_reset();
    test_arp();
    test_ip_lengths();
    test_arp_ip_tie();
    test_back_to_back();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/eth_tx_top.sv */
/*
 * ethernet/ipv4 transmit top level.
 * arp and ip sources share one mac framer through the arbiter.
 */
`timescale 1ns/10ps
`default_nettype none

module eth_tx_top (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  arp_send,
  input  wire eth_tx_pkg::ip_addr_t  arp_target_ip,
  input  wire logic                  ip_wr,
  input  wire eth_tx_pkg::byte_t     ip_wr_data,
  input  wire logic                  ip_send,
  input  wire eth_tx_pkg::mac_addr_t ip_dst_mac,
  input  wire eth_tx_pkg::ip_addr_t  ip_dst_ip,
  input  wire eth_tx_pkg::byte_t     ip_protocol,
  output logic                       arp_busy,
  output logic                       ip_busy,
  output logic                       gmii_tx_en,
  output eth_tx_pkg::byte_t          gmii_txd
);
  import eth_tx_pkg::*;

  logic        arp_req, arp_grant, arp_valid, arp_last;
  byte_t       arp_data;
  logic        ip_req, ip_grant, ip_valid, ip_last;
  byte_t       ip_data;
  logic        mac_valid, mac_last, mac_busy;
  byte_t       mac_data;
  logic        crc_init, crc_en;
  byte_t       crc_data;
  logic [31:0] crc_out;

  arp_tx u_arp_tx (
    .clk(clk), .rst_n(rst_n), .send(arp_send), .target_ip(arp_target_ip),
    .req(arp_req), .grant(arp_grant), .valid(arp_valid), .data(arp_data),
    .last(arp_last), .busy(arp_busy)
  );

  ip_tx u_ip_tx (
    .clk(clk), .rst_n(rst_n), .wr(ip_wr), .wr_data(ip_wr_data), .send(ip_send),
    .dst_mac(ip_dst_mac), .dst_ip(ip_dst_ip), .protocol(ip_protocol),
    .req(ip_req), .grant(ip_grant), .valid(ip_valid), .data(ip_data),
    .last(ip_last), .busy(ip_busy)
  );

  mac_tx_mode u_mac_tx_mode (
    .clk(clk), .rst_n(rst_n),
    .arp_req(arp_req), .arp_grant(arp_grant), .arp_valid(arp_valid),
    .arp_data(arp_data), .arp_last(arp_last),
    .ip_req(ip_req), .ip_grant(ip_grant), .ip_valid(ip_valid),
    .ip_data(ip_data), .ip_last(ip_last),
    .busy(mac_busy), .mac_valid(mac_valid), .mac_data(mac_data), .mac_last(mac_last)
  );

  mac_tx u_mac_tx (
    .clk(clk), .rst_n(rst_n), .mac_valid(mac_valid), .mac_data(mac_data),
    .mac_last(mac_last), .busy(mac_busy), .crc_init(crc_init), .crc_en(crc_en),
    .crc_data(crc_data), .crc_out(crc_out), .gmii_tx_en(gmii_tx_en), .gmii_txd(gmii_txd)
  );

  crc32_d8 u_crc32_d8 (
    .clk(clk), .rst_n(rst_n), .init(crc_init), .en(crc_en), .data(crc_data), .crc(crc_out)
  );

endmodule

`default_nettype wire

/* hw/mac_tx.sv */
/*
 * mac framer with gmii-style output.
 * puts preamble and sfd ahead of the body through an 8-byte delay line,
 * pads to the minimum length, appends the fcs and holds the interframe gap.
 */
`timescale 1ns/10ps
`default_nettype none
`include "eth_tx_cfg.svh"

module mac_tx (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              mac_valid,
  input  wire eth_tx_pkg::byte_t mac_data,
  input  wire logic              mac_last,
  output logic                   busy,
  output logic                   crc_init,
  output logic                   crc_en,
  output eth_tx_pkg::byte_t      crc_data,
  input  wire logic [31:0]       crc_out,
  output logic                   gmii_tx_en,
  output eth_tx_pkg::byte_t      gmii_txd
);
  import eth_tx_pkg::*;

  localparam int MIN_FRAME = `ETH_MIN_FRAME;
  localparam int IFG       = `ETH_IFG;

  typedef enum logic [2:0] {PH_IDLE, PH_PRE, PH_BODY, PH_PAD, PH_FCS, PH_GAP} phase_t;

  phase_t     phase;
  logic [6:0] cnt;
  byte_t      dly [8];
  logic [7:0] dly_v;
  logic [7:0] dly_l;

  always_ff @(posedge clk)
  begin
    dly[0] <= mac_data;
    for (int i = 1; i < 8; i++)
      dly[i] <= dly[i-1];
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      dly_v <= '0;
      dly_l <= '0;
    end
    else
    begin
      dly_v <= {dly_v[6:0], mac_valid};
      dly_l <= {dly_l[6:0], mac_last};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase      <= PH_IDLE;
      cnt        <= '0;
      gmii_tx_en <= 1'b0;
      gmii_txd   <= '0;
    end
    else
    begin
      case (phase)
        PH_IDLE:
        begin
          if (mac_valid)
          begin
            phase      <= PH_PRE;
            cnt        <= 7'd1;
            gmii_tx_en <= 1'b1;
            gmii_txd   <= 8'h55; // first preamble byte.
          end
        end
        PH_PRE:
        begin
          if (cnt == 7'd7)
          begin
            phase    <= PH_BODY;
            cnt      <= '0;
            gmii_txd <= 8'hD5; // sfd.
          end
          else
          begin
            cnt      <= cnt + 7'd1;
            gmii_txd <= 8'h55;
          end
        end
        PH_BODY:
        begin
          if (dly_v[7])
          begin
            gmii_txd <= dly[7];
            cnt      <= cnt + 7'd1;
            if (dly_l[7])
            begin
              if (cnt < 7'(MIN_FRAME - 1))
                phase <= PH_PAD;
              else
              begin
                phase <= PH_FCS;
                cnt   <= '0;
              end
            end
          end
        end
        PH_PAD:
        begin
          gmii_txd <= '0;
          if (cnt == 7'(MIN_FRAME - 1))
          begin
            phase <= PH_FCS;
            cnt   <= '0;
          end
          else
            cnt <= cnt + 7'd1;
        end
        PH_FCS:
        begin
          gmii_txd <= crc_out[cnt[1:0] * 8 +: 8]; // low byte first.
          if (cnt == 7'd3)
          begin
            phase <= PH_GAP;
            cnt   <= '0;
          end
          else
            cnt <= cnt + 7'd1;
        end
        PH_GAP:
        begin
          gmii_tx_en <= 1'b0;
          gmii_txd   <= '0;
          if (cnt == 7'(IFG - 1))
          begin
            phase <= PH_IDLE;
            cnt   <= '0;
          end
          else
            cnt <= cnt + 7'd1;
        end
        default:
          phase <= PH_IDLE;
      endcase
    end
  end

  // crc sees exactly the bytes loaded into gmii_txd for body and pad.
  assign crc_init = (phase == PH_PRE);
  assign crc_en   = ((phase == PH_BODY) && dly_v[7]) || (phase == PH_PAD);
  assign crc_data = (phase == PH_BODY) ? dly[7] : 8'h00;
  assign busy     = (phase != PH_IDLE);

endmodule

`default_nettype wire

/* hw/mac_tx_mode.sv */
/*
 * arbiter between the arp and ip sources.
 * grants one requester while the framer is idle, arp first, and
 * forwards the granted stream to the framer one cycle later.
 */
`timescale 1ns/10ps
`default_nettype none

module mac_tx_mode (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              arp_req,
  output logic                   arp_grant,
  input  wire logic              arp_valid,
  input  wire eth_tx_pkg::byte_t arp_data,
  input  wire logic              arp_last,
  input  wire logic              ip_req,
  output logic                   ip_grant,
  input  wire logic              ip_valid,
  input  wire eth_tx_pkg::byte_t ip_data,
  input  wire logic              ip_last,
  input  wire logic              busy,
  output logic                   mac_valid,
  output eth_tx_pkg::byte_t      mac_data,
  output logic                   mac_last
);
  import eth_tx_pkg::*;

  tx_sel_t state;
  tx_sel_t next_state;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= TX_IDLE;
    else
      state <= next_state;
  end

  // single-cycle grant strobes, arp wins a tie.
  assign arp_grant = (state == TX_IDLE) && !busy && arp_req;
  assign ip_grant  = (state == TX_IDLE) && !busy && !arp_req && ip_req;

  always_comb
  begin
    next_state = state;
    case (state)
      TX_IDLE:
      begin
        if (arp_grant)
          next_state = TX_ARP;
        else if (ip_grant)
          next_state = TX_IP;
      end
      TX_ARP:
      begin
        if (arp_valid && arp_last)
          next_state = TX_IDLE;
      end
      TX_IP:
      begin
        if (ip_valid && ip_last)
          next_state = TX_IDLE;
      end
      default:
        next_state = TX_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mac_valid <= 1'b0;
      mac_data  <= '0;
      mac_last  <= 1'b0;
    end
    else if (state == TX_ARP)
    begin
      mac_valid <= arp_valid;
      mac_data  <= arp_data;
      mac_last  <= arp_last;
    end
    else if (state == TX_IP)
    begin
      mac_valid <= ip_valid;
      mac_data  <= ip_data;
      mac_last  <= ip_last;
    end
    else
    begin
      mac_valid <= 1'b0;
      mac_data  <= '0;
      mac_last  <= 1'b0;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) !(arp_grant && ip_grant));
  // source answers the grant at once, framer sees it one cycle later.
  assert property (@(posedge clk) disable iff (!rst_n) (arp_grant || ip_grant) |-> ##2 mac_valid);

endmodule

`default_nettype wire

/* hw/ip_tx.sv */
/*
 * ipv4 packet source.
 * wr fills the payload buffer; send builds the header, folds its checksum
 * in three cycles, raises req and streams mac header, ip header and payload.
 */
`timescale 1ns/10ps
`default_nettype none
`include "eth_tx_cfg.svh"

module ip_tx (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  wr,
  input  wire eth_tx_pkg::byte_t     wr_data,
  input  wire logic                  send,
  input  wire eth_tx_pkg::mac_addr_t dst_mac,
  input  wire eth_tx_pkg::ip_addr_t  dst_ip,
  input  wire eth_tx_pkg::byte_t     protocol,
  output logic                       req,
  input  wire logic                  grant,
  output logic                       valid,
  output eth_tx_pkg::byte_t          data,
  output logic                       last,
  output logic                       busy
);
  import eth_tx_pkg::*;

  localparam int       DEPTH    = `IP_PAYLOAD_DEPTH;
  localparam int       AW       = $clog2(DEPTH);
  localparam int       HDR_LEN  = 34; // mac 14 plus ip 20.
  localparam int       IW       = $clog2(HDR_LEN + DEPTH);
  localparam ip_addr_t LOCAL_IP = `ETH_LOCAL_IP;

  typedef enum logic [2:0] {S_IDLE, S_SUM, S_FOLD, S_CSUM, S_REQ, S_SEND} ip_state_t;

  ip_state_t          state;
  byte_t              mem [DEPTH];
  logic [AW:0]        count;
  logic [IW-1:0]      idx;
  logic [AW-1:0]      rd_addr;
  mac_addr_t          dst_mac_q;
  ip_addr_t           dst_ip_q;
  byte_t              proto_q;
  logic [15:0]        ident;
  logic [15:0]        tot_len;
  logic [15:0]        csum;
  logic [18:0]        sum_a;
  logic [18:0]        sum_b;
  logic [19:0]        sum_all;
  logic [16:0]        fold;
  logic [HDR_LEN*8-1:0] hdr;
  logic               accept_send;
  logic               accept_wr;

  assign accept_send = send && (state == S_IDLE) && (count != '0); // empty sends dropped.
  assign accept_wr   = wr && (state == S_IDLE) && !accept_send && (count < (AW+1)'(DEPTH));
  assign tot_len     = 16'd20 + 16'(count);
  assign sum_all     = 20'(sum_a) + 20'(sum_b);

  always_ff @(posedge clk)
  begin
    if (accept_wr)
      mem[count[AW-1:0]] <= wr_data;
    if (accept_send)
    begin
      dst_mac_q <= dst_mac;
      dst_ip_q  <= dst_ip;
      proto_q   <= protocol;
    end
    if (state == S_SUM)
    begin
      sum_a <= 19'h04500 + 19'(tot_len) + 19'(ident) + 19'h04000 + 19'({8'd64, proto_q});
      sum_b <= 19'(LOCAL_IP[31:16]) + 19'(LOCAL_IP[15:0])
             + 19'(dst_ip_q[31:16]) + 19'(dst_ip_q[15:0]);
    end
    if (state == S_FOLD)
      fold <= 17'(sum_all[15:0]) + 17'(sum_all[19:16]);
    if (state == S_CSUM)
      csum <= ~(fold[15:0] + 16'(fold[16])); // second fold cannot carry.
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= S_IDLE;
      count <= '0;
      idx   <= '0;
      req   <= 1'b0;
      ident <= '0;
    end
    else
    begin
      case (state)
        S_IDLE:
        begin
          if (accept_send)
            state <= S_SUM;
          else if (accept_wr)
            count <= count + 1'b1;
        end
        S_SUM:
          state <= S_FOLD;
        S_FOLD:
          state <= S_CSUM;
        S_CSUM:
        begin
          state <= S_REQ;
          req   <= 1'b1;
        end
        S_REQ:
        begin
          if (grant)
          begin
            req   <= 1'b0;
            idx   <= '0;
            state <= S_SEND;
          end
        end
        S_SEND:
        begin
          if (last)
          begin
            state <= S_IDLE;
            count <= '0;
            ident <= ident + 16'd1; // next packet id.
          end
          else
            idx <= idx + 1'b1;
        end
        default:
          state <= S_IDLE;
      endcase
    end
  end

  assign hdr = {dst_mac_q, `ETH_LOCAL_MAC, 16'h0800, 8'h45, 8'h00, tot_len, ident,
                16'h4000, 8'd64, proto_q, csum, LOCAL_IP, dst_ip_q};

  assign rd_addr = AW'(idx - IW'(HDR_LEN));

  always_comb
  begin
    if (idx < IW'(HDR_LEN))
      data = hdr[(HDR_LEN - 1 - idx) * 8 +: 8];
    else
      data = mem[rd_addr];
  end

  assign valid = (state == S_SEND);
  assign last  = valid && (idx == IW'(HDR_LEN - 1 + count));
  assign busy  = (state != S_IDLE);

  assert property (@(posedge clk) disable iff (!rst_n) count <= (AW+1)'(DEPTH));

endmodule

`default_nettype wire

/* hw/arp_tx.sv */
/*
 * arp request source.
 * send latches the target ip and raises req; after the grant the
 * 42-byte body (mac header plus arp fields) streams without gaps.
 */
`timescale 1ns/10ps
`default_nettype none
`include "eth_tx_cfg.svh"

module arp_tx (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 send,
  input  wire eth_tx_pkg::ip_addr_t target_ip,
  output logic                      req,
  input  wire logic                 grant,
  output logic                      valid,
  output eth_tx_pkg::byte_t         data,
  output logic                      last,
  output logic                      busy
);
  import eth_tx_pkg::*;

  localparam int FRAME_LEN = 42;

  ip_addr_t               tgt_ip;
  logic [5:0]             idx;
  logic                   active;
  logic [FRAME_LEN*8-1:0] frame;

  always_ff @(posedge clk)
  begin
    if (send && !busy)
      tgt_ip <= target_ip;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req    <= 1'b0;
      active <= 1'b0;
      idx    <= '0;
    end
    else
    begin
      if (send && !busy)
        req <= 1'b1;
      else if (grant)
        req <= 1'b0;
      if (grant)
      begin
        active <= 1'b1;
        idx    <= '0;
      end
      else if (active)
      begin
        idx <= idx + 6'd1;
        if (last)
          active <= 1'b0;
      end
    end
  end

  // broadcast header, then an arp request with zero target mac.
  assign frame = {48'hFFFF_FFFF_FFFF, `ETH_LOCAL_MAC, 16'h0806,
                  16'h0001, 16'h0800, 8'h06, 8'h04, 16'h0001,
                  `ETH_LOCAL_MAC, `ETH_LOCAL_IP, 48'h0, tgt_ip};

  assign valid = active;
  assign data  = frame[(FRAME_LEN - 1 - idx) * 8 +: 8]; // first byte at the top.
  assign last  = active && (idx == 6'(FRAME_LEN - 1));
  assign busy  = req || active;

  // a stream never starts on its own.
  assert property (@(posedge clk) disable iff (!rst_n) $rose(valid) |-> $past(grant));

endmodule

`default_nettype wire

/* hw/crc32_d8.sv */
/*
 * ethernet fcs engine, one byte per clock.
 * init presets the register, en folds in data; crc[7:0] goes out first.
 */
`timescale 1ns/10ps
`default_nettype none

module crc32_d8 (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              init,
  input  wire logic              en,
  input  wire eth_tx_pkg::byte_t data,
  output logic [31:0]            crc
);

  logic [31:0] crc_q;

  // reflected 04C11DB7, data lsb first.
  function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    r = c;
    for (int i = 0; i < 8; i++)
    begin
      r = (r[0] ^ d[i]) ? ((r >> 1) ^ 32'hEDB8_8320) : (r >> 1);
    end
    return r;
  endfunction

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      crc_q <= '1;
    else if (init)
      crc_q <= '1;
    else if (en)
      crc_q <= crc_step(crc_q, data);
  end

  assign crc = ~crc_q; // final inversion.

endmodule

`default_nettype wire

/* hw/eth_tx_pkg.sv */
/*
 * shared types of the ethernet transmit path.
 * imported by the frame sources, the arbiter, the framer and the top level.
 */
`default_nettype none

package eth_tx_pkg;

  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [7:0]  byte_t;

  // arbiter state, one-hot.
  typedef enum logic [2:0] {
    TX_IDLE = 3'b001,
    TX_ARP  = 3'b010,
    TX_IP   = 3'b100
  } tx_sel_t;

endpackage

`default_nettype wire

/* hw/eth_tx_cfg.svh */
/*
 * build constants of the transmit path.
 * include in any module that needs addresses or frame limits.
 */
`ifndef ETH_TX_CFG_SVH
`define ETH_TX_CFG_SVH

// station addresses.
`define ETH_LOCAL_MAC 48'h02_00_00_00_00_01
`define ETH_LOCAL_IP  32'hC0_A8_01_0A

// payload buffer in bytes, power of two.
`define IP_PAYLOAD_DEPTH 64

// frame limits.
`define ETH_MIN_FRAME 60
`define ETH_IFG       12

`endif
